/* logic/board_pkg.sv */
// Reset hold and LED stretch lengths are cut down for simulation and must fit their 5-bit counters
package board_pkg;

	// -------------------------------------------------------------------
	// Reset sequencing
	// -------------------------------------------------------------------
	// Reset pin synchronizer depth, at least 2
	localparam int unsigned SYNC_STAGES = 2;
	// Settled pin-high cycles before system reset release
	localparam int unsigned SYS_HOLD_CYCLES = 16;
	// Cycles before flash/codec/PHY reset release
	localparam int unsigned PERIPH_HOLD_CYCLES = 8;
	localparam int unsigned HOLD_CNT_W = 5;
	typedef logic [HOLD_CNT_W-1:0] hold_cnt_t;

	// -------------------------------------------------------------------
	// Activity LEDs
	// -------------------------------------------------------------------
	// LED on-time after the serial line returns high
	localparam int unsigned STRETCH_CYCLES = 31;
	localparam int unsigned STRETCH_CNT_W = 5;
	typedef logic [STRETCH_CNT_W-1:0] stretch_cnt_t;

	// -------------------------------------------------------------------
	// Board pins
	// -------------------------------------------------------------------
	localparam int unsigned BTN_W = 5;
	localparam int unsigned DIPSW_W = 8;
	localparam int unsigned LED_W = 4;
	localparam int unsigned BTNLED_W = 5;
	localparam int unsigned LCD_D_W = 4;
	// Buttons in the low bits, switches above them
	localparam int unsigned GPIO_IN_W = BTN_W + DIPSW_W;
	// Two LEDs, button LEDs, three LCD strobes and the LCD nibble
	localparam int unsigned GPIO_OUT_W = 14;
	typedef logic [GPIO_IN_W-1:0] gpio_in_t;
	typedef logic [GPIO_OUT_W-1:0] gpio_out_t;

endpackage

/* logic/csr_pkg.sv */
// CSR addresses are word addresses with a 4-bit bank over a 10-bit register offset
package csr_pkg;

	// -------------------------------------------------------------------
	// Bus widths
	// -------------------------------------------------------------------
	localparam int unsigned CSR_BANK_W = 4;
	localparam int unsigned CSR_REG_W = 10;
	localparam int unsigned CSR_ADDR_W = CSR_BANK_W + CSR_REG_W;
	localparam int unsigned CSR_DATA_W = 32;

	typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
	typedef logic [CSR_DATA_W-1:0] csr_data_t;
	// Upper address field, selects the peripheral
	typedef logic [CSR_BANK_W-1:0] csr_bank_t;
	// Lower address field, selects the register
	typedef logic [CSR_REG_W-1:0] csr_reg_t;

	// -------------------------------------------------------------------
	// System controller map
	// -------------------------------------------------------------------
	localparam csr_bank_t SYSCTL_BANK = 4'h1;

	// Switches and buttons, read only
	localparam csr_reg_t REG_GPIO_IN = 10'd0;
	// LED, button LED and LCD outputs
	localparam csr_reg_t REG_GPIO_OUT = 10'd1;
	// Board identifier, read only
	localparam csr_reg_t REG_SYSTEM_ID = 10'd2;
	// Any write triggers a system reset, reads as zero
	localparam csr_reg_t REG_HARD_RESET = 10'd3;

	// ASCII "X401"
	localparam csr_data_t SYSTEM_ID = 32'h58343031;

endpackage

/* logic/reset_sequencer.sv */
// Reset pin is sampled unfiltered so any low restarts both holds and the pin must stay high to release
`timescale 1ns/10ps

module reset_sequencer (
	input  logic sys_clk,
	input  logic rst_n_i,
	input  logic hard_reset_i,
	output logic sys_rst_n_o,
	output logic periph_rst_n_o
);
	import board_pkg::*;

	// Release order is peripheral first, then system
	typedef enum logic [1:0] {
		HOLD_ALL,
		HOLD_SYS,
		RUN
	} seq_state_t;

	logic [SYNC_STAGES-1:0] pin_sync_q;
	logic                   pin_high;
	seq_state_t             state_q;
	hold_cnt_t              hold_cnt_q;

	// -------------------------------------------------------------------
	// Pin synchronizer
	// -------------------------------------------------------------------
	// Low pin clears the chain at once, high shifts through
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i) begin
			pin_sync_q <= '0;
		end else begin
			pin_sync_q <= {pin_sync_q[SYNC_STAGES-2:0], 1'b1};
		end
	end

	assign pin_high = pin_sync_q[SYNC_STAGES-1];

	// -------------------------------------------------------------------
	// Hold sequencing
	// -------------------------------------------------------------------
	// One counter runs through both holds
	// Outputs are set on the transition edge itself
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i || !pin_high) begin
			state_q        <= HOLD_ALL;
			hold_cnt_q     <= '0;
			sys_rst_n_o    <= 1'b0;
			periph_rst_n_o <= 1'b0;
		end else begin
			case (state_q)
				HOLD_ALL: begin
					hold_cnt_q <= hold_cnt_q + 1'b1;
					// Flash and codec need to be out of reset before the CPU fetches
					if (hold_cnt_q == hold_cnt_t'(PERIPH_HOLD_CYCLES - 1)) begin
						state_q        <= HOLD_SYS;
						periph_rst_n_o <= 1'b1;
					end
				end
				HOLD_SYS: begin
					hold_cnt_q <= hold_cnt_q + 1'b1;
					if (hold_cnt_q == hold_cnt_t'(SYS_HOLD_CYCLES - 1)) begin
						state_q     <= RUN;
						sys_rst_n_o <= 1'b1;
					end
				end
				RUN: begin
					// Software reset, full system hold, peripherals untouched
					if (hard_reset_i) begin
						state_q     <= HOLD_SYS;
						hold_cnt_q  <= '0;
						sys_rst_n_o <= 1'b0;
					end
				end
				default: begin
					state_q <= HOLD_ALL;
				end
			endcase
		end
	end

	// System never runs with flash/codec/PHY still held
	a_sys_after_periph: assert property (
		@(posedge sys_clk) sys_rst_n_o |-> periph_rst_n_o
	) else $error("system reset released while peripheral reset is held");

endmodule

/* logic/activity_stretch.sv */
// Line is sampled without synchronization so the LED may lag a short glitch by a cycle
`timescale 1ns/10ps

module activity_stretch (
	input  logic sys_clk,
	input  logic rst_n_i,
	input  logic line_i,
	output logic led_o
);
	import board_pkg::*;

	stretch_cnt_t cnt_q;

	// Serial lines idle high, a start bit or data low retriggers
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i) begin
			cnt_q <= '0;
			led_o <= 1'b0;
		end else begin
			if (!line_i) begin
				cnt_q <= stretch_cnt_t'(STRETCH_CYCLES);
			end else if (cnt_q != '0) begin
				cnt_q <= cnt_q - 1'b1;
			end
			// LED follows the counter one edge later
			led_o <= (cnt_q != '0);
		end
	end

	a_low_lights_led: assert property (
		@(posedge sys_clk) disable iff (!rst_n_i)
		!line_i |-> ##[1:2] led_o
	) else $error("activity LED did not light after a low line");

endmodule

/* logic/sysctl_csr.sv */
// Writes are single-cycle strobes with no ack and GPIO inputs are read unsynchronized
`timescale 1ns/10ps

module sysctl_csr (
	input  logic                 sys_clk,
	input  logic                 rst_n_i,
	input  csr_pkg::csr_addr_t   csr_a_i,
	input  logic                 csr_we_i,
	input  csr_pkg::csr_data_t   csr_dw_i,
	input  board_pkg::gpio_in_t  gpio_in_i,
	output csr_pkg::csr_data_t   csr_dr_o,
	output board_pkg::gpio_out_t gpio_out_o,
	output logic                 hard_reset_o
);
	import board_pkg::*;
	import csr_pkg::*;

	csr_bank_t bank;
	csr_reg_t  offset;
	logic      csr_sel;

	// -------------------------------------------------------------------
	// Address decode
	// -------------------------------------------------------------------
	assign bank    = csr_a_i[CSR_ADDR_W-1:CSR_REG_W];
	assign offset  = csr_a_i[CSR_REG_W-1:0];
	assign csr_sel = (bank == SYSCTL_BANK);

	// -------------------------------------------------------------------
	// Write side
	// -------------------------------------------------------------------
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i) begin
			gpio_out_o   <= '0;
			hard_reset_o <= 1'b0;
		end else begin
			// Pulse lasts one cycle
			hard_reset_o <= 1'b0;
			if (csr_sel && csr_we_i) begin
				case (offset)
					REG_GPIO_OUT: begin
						gpio_out_o <= csr_dw_i[GPIO_OUT_W-1:0];
					end
					REG_HARD_RESET: begin
						// Data ignored
						hard_reset_o <= 1'b1;
					end
					default: begin
					end
				endcase
			end
		end
	end

	// -------------------------------------------------------------------
	// Read side
	// -------------------------------------------------------------------
	// Address in cycle N, data in cycle N+1
	// Unselected banks drive zero so slaves can be OR-combined
	always_ff @(posedge sys_clk) begin
		if (!rst_n_i) begin
			csr_dr_o <= '0;
		end else begin
			csr_dr_o <= '0;
			if (csr_sel) begin
				case (offset)
					REG_GPIO_IN: begin
						csr_dr_o <= csr_data_t'(gpio_in_i);
					end
					REG_GPIO_OUT: begin
						csr_dr_o <= csr_data_t'(gpio_out_o);
					end
					REG_SYSTEM_ID: begin
						csr_dr_o <= SYSTEM_ID;
					end
					// Hard reset and unmapped offsets read zero
					default: begin
						csr_dr_o <= '0;
					end
				endcase
			end
		end
	end

	a_foreign_bank_zero: assert property (
		@(posedge sys_clk) disable iff (!rst_n_i)
		(bank != SYSCTL_BANK) |=> (csr_dr_o == '0)
	) else $error("system controller drove read data for another bank");

endmodule

/* logic/board_ctrl_top.sv */
// UART lines are monitored only and the GPIO-to-pin mapping is fixed for this board
`timescale 1ns/10ps

module board_ctrl_top (
	input  logic                         sys_clk,
	input  logic                         rst_n_i,
	input  csr_pkg::csr_addr_t           csr_a_i,
	input  logic                         csr_we_i,
	input  csr_pkg::csr_data_t           csr_dw_i,
	output csr_pkg::csr_data_t           csr_dr_o,
	input  logic [board_pkg::BTN_W-1:0]  btn_i,
	input  logic [board_pkg::DIPSW_W-1:0] dipsw_i,
	input  logic                         uart_rxd_i,
	input  logic                         uart_txd_i,
	output logic [board_pkg::LED_W-1:0]  led_o,
	output logic [board_pkg::BTNLED_W-1:0] btnled_o,
	output logic                         lcd_e_o,
	output logic                         lcd_rs_o,
	output logic                         lcd_rw_o,
	output logic [board_pkg::LCD_D_W-1:0] lcd_d_o,
	output logic                         sys_rst_n_o,
	output logic                         periph_rst_n_o
);
	import board_pkg::*;

	logic      sys_rst_n;
	logic      periph_rst_n;
	logic      hard_reset;
	logic      rx_led;
	logic      tx_led;
	gpio_in_t  gpio_in;
	gpio_out_t gpio_out;

	// -------------------------------------------------------------------
	// Reset generation
	// -------------------------------------------------------------------
	reset_sequencer rst_seq (
		.sys_clk        (sys_clk),
		.rst_n_i        (rst_n_i),
		.hard_reset_i   (hard_reset),
		.sys_rst_n_o    (sys_rst_n),
		.periph_rst_n_o (periph_rst_n)
	);

	assign sys_rst_n_o    = sys_rst_n;
	// Shared by flash, codec and PHY
	assign periph_rst_n_o = periph_rst_n;

	// -------------------------------------------------------------------
	// System controller
	// -------------------------------------------------------------------
	// Buttons low, switches high
	assign gpio_in = {dipsw_i, btn_i};

	sysctl_csr sysctl (
		.sys_clk      (sys_clk),
		.rst_n_i      (sys_rst_n),
		.csr_a_i      (csr_a_i),
		.csr_we_i     (csr_we_i),
		.csr_dw_i     (csr_dw_i),
		.gpio_in_i    (gpio_in),
		.csr_dr_o     (csr_dr_o),
		.gpio_out_o   (gpio_out),
		.hard_reset_o (hard_reset)
	);

	// LEDs 1 and 0 belong to the UART monitors
	assign led_o    = {gpio_out[1:0], rx_led, tx_led};
	assign btnled_o = gpio_out[6:2];
	assign lcd_e_o  = gpio_out[7];
	assign lcd_rs_o = gpio_out[8];
	assign lcd_rw_o = gpio_out[9];
	assign lcd_d_o  = gpio_out[13:10];

	// UART activity indicators
	activity_stretch rx_stretch (
		.sys_clk (sys_clk),
		.rst_n_i (sys_rst_n),
		.line_i  (uart_rxd_i),
		.led_o   (rx_led)
	);

	activity_stretch tx_stretch (
		.sys_clk (sys_clk),
		.rst_n_i (sys_rst_n),
		.line_i  (uart_txd_i),
		.led_o   (tx_led)
	);

endmodule

/* verif/tb_clock_gen.sv */
// Free-running clock that starts low at time zero and never stops on its own
`timescale 1ns/10ps

module tb_clock_gen (
	output logic sys_clk_o
);

	// 20 ns period, 10 ns per half
	initial begin
		sys_clk_o = 1'b0;
		forever begin
			#10 sys_clk_o = ~sys_clk_o;
		end
	end

endmodule

/* verif/tb_board_ctrl.sv */
// Run from the project root so the vector file path resolves, stops at the first mismatch
`timescale 1ns/10ps

module tb_board_ctrl;
	import board_pkg::*;
	import csr_pkg::*;

	logic                  sys_clk;
	logic                  rst_n_i;
	csr_addr_t             csr_a_i;
	logic                  csr_we_i;
	csr_data_t             csr_dw_i;
	csr_data_t             csr_dr_o;
	logic [BTN_W-1:0]      btn_i;
	logic [DIPSW_W-1:0]    dipsw_i;
	logic                  uart_rxd_i;
	logic                  uart_txd_i;
	logic [LED_W-1:0]      led_o;
	logic [BTNLED_W-1:0]   btnled_o;
	logic                  lcd_e_o;
	logic                  lcd_rs_o;
	logic                  lcd_rw_o;
	logic [LCD_D_W-1:0]    lcd_d_o;
	logic                  sys_rst_n_o;
	logic                  periph_rst_n_o;

	// Parsed vectors, one entry per line
	logic [7:0] op_q[$];
	csr_addr_t  addr_q[$];
	csr_data_t  data_q[$];
	csr_data_t  exp_q[$];
	int         cycle_cnt = 0;
	int         cycle_limit = 0;

	tb_clock_gen clk_gen (.sys_clk_o(sys_clk));

	board_ctrl_top dut0 (
		.sys_clk        (sys_clk),
		.rst_n_i        (rst_n_i),
		.csr_a_i        (csr_a_i),
		.csr_we_i       (csr_we_i),
		.csr_dw_i       (csr_dw_i),
		.csr_dr_o       (csr_dr_o),
		.btn_i          (btn_i),
		.dipsw_i        (dipsw_i),
		.uart_rxd_i     (uart_rxd_i),
		.uart_txd_i     (uart_txd_i),
		.led_o          (led_o),
		.btnled_o       (btnled_o),
		.lcd_e_o        (lcd_e_o),
		.lcd_rs_o       (lcd_rs_o),
		.lcd_rw_o       (lcd_rw_o),
		.lcd_d_o        (lcd_d_o),
		.sys_rst_n_o    (sys_rst_n_o),
		.periph_rst_n_o (periph_rst_n_o)
	);

	// ---------------------------------------------------------------------
	// Helpers and compare tasks
	// ---------------------------------------------------------------------
	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "Simulation stopped");
	endtask

	// Drive point, 2 ns after the rising edge, outputs settled
	task automatic next_cycle();
		@(posedge sys_clk);
		#2;
	endtask

	task automatic check_data(input string what, input csr_data_t got, input csr_data_t exp);
		if (got !== exp) begin
			stop_run($sformatf("Fail at %0d ns: %s read %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_gpio(input gpio_out_t got, input gpio_out_t exp);
		if (got !== exp) begin
			stop_run($sformatf("Fail at %0d ns: GPIO pins %h, expected %h", $time, got, exp));
		end
	endtask

	task automatic check_reset_window(input string what, input int n, input int lo, input int hi);
		if (n < lo || n > hi) begin
			stop_run($sformatf("Fail at %0d ns: %s took %0d cycles, expected %0d to %0d",
				$time, what, n, lo, hi));
		end
	endtask

	// Pins gathered back into GPIO register order
	function automatic gpio_out_t pin_word();
		return {lcd_d_o, lcd_rw_o, lcd_rs_o, lcd_e_o, btnled_o, led_o[3:2]};
	endfunction

	// Rx monitor on led 1, tx monitor on led 0
	function automatic logic activity_led(input logic is_tx);
		return is_tx ? led_o[0] : led_o[1];
	endfunction

	// Worst-case cycles per operation
	function automatic int op_budget(input logic [7:0] op);
		case (op)
			"P": return 40;
			"H": return 35;
			"X": return 45;
			default: return 3;
		endcase
	endfunction

	// ---------------------------------------------------------------------
	// Operations
	// ---------------------------------------------------------------------
	task automatic csr_write(input csr_addr_t addr, input csr_data_t data);
		csr_a_i  = addr;
		csr_dw_i = data;
		csr_we_i = 1'b1;
		next_cycle();
		csr_we_i = 1'b0;
	endtask

	// Data registered one cycle after the address
	task automatic csr_read(input csr_addr_t addr, input csr_data_t exp);
		csr_a_i = addr;
		next_cycle();
		check_data($sformatf("address %h", addr), csr_dr_o, exp);
	endtask

	task automatic pin_reset();
		int n;
		int high_cnt;
		int periph_n;
		int sys_n;
		n        = 0;
		high_cnt = 0;
		periph_n = 0;
		sys_n    = 0;
		csr_we_i = 1'b0;
		rst_n_i  = 1'b0;
		repeat (4) begin
			next_cycle();
			if (sys_rst_n_o || periph_rst_n_o) high_cnt++;
		end
		check_reset_window("reset outputs high while pin low", high_cnt, 0, 0);
		rst_n_i = 1'b1;
		while (n < 30 && sys_n == 0) begin
			next_cycle();
			n++;
			if (periph_rst_n_o && periph_n == 0) periph_n = n;
			if (sys_rst_n_o) sys_n = n;
		end
		check_reset_window("peripheral reset release", periph_n, PERIPH_HOLD_CYCLES,
			PERIPH_HOLD_CYCLES + 3);
		check_reset_window("system reset release", sys_n, SYS_HOLD_CYCLES, SYS_HOLD_CYCLES + 3);
	endtask

	// Cycles counted from the write edge
	task automatic hard_reset(input csr_addr_t addr);
		int n;
		int drop_n;
		int rise_n;
		int periph_low;
		n          = 0;
		drop_n     = 0;
		rise_n     = 0;
		periph_low = 0;
		csr_write(addr, '0);
		while (n < 30 && rise_n == 0) begin
			next_cycle();
			n++;
			if (!periph_rst_n_o) periph_low++;
			if (!sys_rst_n_o && drop_n == 0) drop_n = n;
			if (sys_rst_n_o && drop_n != 0) rise_n = n;
		end
		check_reset_window("system reset drop after hard reset", drop_n, 1, 2);
		check_reset_window("system reset hold after hard reset", rise_n - drop_n,
			SYS_HOLD_CYCLES, SYS_HOLD_CYCLES + 3);
		check_reset_window("peripheral reset low during hard reset", periph_low, 0, 0);
	endtask

	// Three-cycle low, then time the LED on and off
	task automatic line_pulse(input logic is_tx);
		int n;
		int lit_n;
		n     = 0;
		lit_n = 0;
		if (is_tx) uart_txd_i = 1'b0;
		else uart_rxd_i = 1'b0;
		while (n < 3) begin
			next_cycle();
			n++;
			if (activity_led(is_tx) && lit_n == 0) lit_n = n;
		end
		check_reset_window("activity LED on", lit_n, 1, 2);
		uart_rxd_i = 1'b1;
		uart_txd_i = 1'b1;
		n = 0;
		do begin
			next_cycle();
			n++;
		end while (activity_led(is_tx) && n < 40);
		check_reset_window("activity LED off", n, STRETCH_CYCLES, STRETCH_CYCLES + 2);
	endtask

	// Buttons in bits 4..0, switches in bits 12..5
	task automatic set_inputs(input csr_addr_t addr);
		csr_data_t exp;
		btn_i   = BTN_W'($urandom);
		dipsw_i = DIPSW_W'($urandom);
		exp     = (csr_data_t'(dipsw_i) << 5) | csr_data_t'(btn_i);
		csr_read(addr, exp);
	endtask

	// ---------------------------------------------------------------------
	// Timeout and main sequence
	// ---------------------------------------------------------------------
	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			stop_run($sformatf("Run timed out after %0d cycles", cycle_cnt));
		end
	end

	initial begin
		int          fd;
		int          budget;
		string       line;
		logic [63:0] op;
		csr_addr_t   addr;
		csr_data_t   data;
		csr_data_t   exp;
		rst_n_i    = 1'b0;
		csr_a_i    = '0;
		csr_we_i   = 1'b0;
		csr_dw_i   = '0;
		btn_i      = '0;
		dipsw_i    = '0;
		uart_rxd_i = 1'b1;
		uart_txd_i = 1'b1;
		budget     = 0;
		void'($urandom(32'h8159));
		fd = $fopen("verif/board_ctrl_vectors.txt", "r");
		if (fd == 0) stop_run("Could not open the vector file verif/board_ctrl_vectors.txt");
		// Comment lines start with #
		while ($fgets(line, fd) > 0) begin
			if (line.len() > 1 && line.getc(0) != "#") begin
				if ($sscanf(line, "%s %h %h %h", op, addr, data, exp) == 4) begin
					op_q.push_back(op[7:0]);
					addr_q.push_back(addr);
					data_q.push_back(data);
					exp_q.push_back(exp);
					budget += op_budget(op[7:0]);
				end
			end
		end
		$fclose(fd);
		cycle_limit = 2 * budget;
		foreach (op_q[i]) begin
			case (op_q[i])
				"P": pin_reset();
				"W": begin
					csr_write(addr_q[i], data_q[i]);
					check_gpio(pin_word(), gpio_out_t'(exp_q[i]));
				end
				"R": csr_read(addr_q[i], exp_q[i]);
				"S": set_inputs(addr_q[i]);
				"H": hard_reset(addr_q[i]);
				"X": line_pulse(addr_q[i][0]);
				default: stop_run($sformatf("Unknown operation %s in the vector file", op_q[i]));
			endcase
		end
		$display("Verification passed");
		$finish;
	end

endmodule

/* verif/board_ctrl_vectors.txt */
# op addr data expect (hex); W write and pin check, R read, P pin reset, H hard reset write
# S random switches and buttons read back, X line pulse with addr 0 for rx and 1 for tx
P 0 0 0
R 401 0 0
W 401 2a5f 2a5f
R 401 0 2a5f
W 401 ffffc3a1 3a1
R 401 0 3a1
R 402 0 58343031
R 802 0 0
R 405 0 0
R 403 0 0
S 400 0 0
S 400 0 0
S 400 0 0
X 0 0 0
X 1 0 0
W 401 1555 1555
H 403 0 0
R 401 0 0
R 402 0 58343031
P 0 0 0
R 401 0 0

/* tb.f */
logic/board_pkg.sv
logic/csr_pkg.sv
logic/reset_sequencer.sv
logic/activity_stretch.sv
logic/sysctl_csr.sv
logic/board_ctrl_top.sv
verif/tb_clock_gen.sv
verif/tb_board_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the board control testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_board_ctrl -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "Verification failed" sim.log; then
	exit 1
fi
if ! grep -q "Verification passed" sim.log; then
	exit 1
fi
